// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [XLEN-1:0] BOOT_ADDR = '0;

	// Major opcodes in RV32I encoding
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic {
		OPA_RS1,
		OPA_ZERO
	} op_a_sel_e;

	typedef enum logic {
		OPB_RS2,
		OPB_IMM
	} op_b_sel_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT
	} br_cond_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

	typedef enum logic [1:0] {
		FS_REQ,
		FS_WAIT_INSTR,
		FS_EXEC
	} fetch_state_e;

endpackage

`default_nettype wire

// ==== hw/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
(
	input  wire                      clk,
	input  wire                      arst_n_i,
	input  wire                      imem_ready_i,
	input  wire  [rv_pkg::XLEN-1:0]  imem_rdata_i,
	input  wire                      retire_i,
	input  wire                      branch_taken_i,
	input  wire                      jump_i,
	input  wire  [rv_pkg::XLEN-1:0]  imm_i,
	output logic                     imem_valid_o,
	output logic [rv_pkg::XLEN-1:0]  imem_addr_o,
	output logic [rv_pkg::XLEN-1:0]  instr_o,
	output logic [rv_pkg::XLEN-1:0]  instr_addr_o,
	output logic                     exec_o
);

	rv_pkg::fetch_state_e     state_q;
	logic [rv_pkg::XLEN-1:0]  pc_q;
	logic [rv_pkg::XLEN-1:0]  instr_q;
	logic [rv_pkg::XLEN-1:0]  pc_next;

	// Taken branch or jump goes PC relative
	assign pc_next = (branch_taken_i || jump_i) ? pc_q + imm_i : pc_q + rv_pkg::XLEN'(4);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= rv_pkg::FS_REQ;
			pc_q    <= rv_pkg::BOOT_ADDR;
		end
		else
		begin
			case (state_q)
				rv_pkg::FS_REQ:
					state_q <= rv_pkg::FS_WAIT_INSTR;
				rv_pkg::FS_WAIT_INSTR:
					if (imem_ready_i)
						state_q <= rv_pkg::FS_EXEC;
				rv_pkg::FS_EXEC:
					if (retire_i)
					begin
						state_q <= rv_pkg::FS_REQ;
						pc_q    <= pc_next;
					end
				default:
					state_q <= rv_pkg::FS_REQ;
			endcase
		end
	end

	// Word held until the instruction retires
	always_ff @(posedge clk)
	begin
		if (state_q == rv_pkg::FS_WAIT_INSTR && imem_ready_i)
			instr_q <= imem_rdata_i;
	end

	assign imem_valid_o = (state_q == rv_pkg::FS_WAIT_INSTR);
	assign imem_addr_o  = pc_q;
	assign instr_o      = instr_q;
	assign instr_addr_o = pc_q;
	assign exec_o       = (state_q == rv_pkg::FS_EXEC);

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
(
	input  wire  [rv_pkg::XLEN-1:0]        instr_i,
	output logic [rv_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
	output logic [rv_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
	output logic [rv_pkg::REG_ADDR_W-1:0]  rd_addr_o,
	output logic                           rf_we_o,
	output rv_pkg::alu_op_e                alu_op_o,
	output rv_pkg::op_a_sel_e              op_a_sel_o,
	output rv_pkg::op_b_sel_e              op_b_sel_o,
	output rv_pkg::br_cond_e               br_cond_o,
	output logic [rv_pkg::XLEN-1:0]        imm_o,
	output rv_pkg::wb_sel_e                wb_sel_o,
	output logic                           mem_read_o,
	output logic                           mem_write_o,
	output logic                           jump_o
);

	rv_pkg::opcode_e          opcode;
	logic [2:0]               funct3;
	logic                     funct7_5;
	logic [rv_pkg::XLEN-1:0]  imm_i_type;
	logic [rv_pkg::XLEN-1:0]  imm_s_type;
	logic [rv_pkg::XLEN-1:0]  imm_b_type;
	logic [rv_pkg::XLEN-1:0]  imm_u_type;
	logic [rv_pkg::XLEN-1:0]  imm_j_type;
	logic                     rf_we;

	assign opcode   = rv_pkg::opcode_e'(instr_i[6:0]);
	assign funct3   = instr_i[14:12];
	assign funct7_5 = instr_i[30];

	assign rs1_addr_o = instr_i[19:15];
	assign rs2_addr_o = instr_i[24:20];
	assign rd_addr_o  = instr_i[11:7];

	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb
	begin
		// Defaults describe a no-op
		rf_we       = 1'b0;
		alu_op_o    = rv_pkg::ALU_PASS_B;
		op_a_sel_o  = rv_pkg::OPA_ZERO;
		op_b_sel_o  = rv_pkg::OPB_IMM;
		br_cond_o   = rv_pkg::BR_NONE;
		imm_o       = imm_i_type;
		wb_sel_o    = rv_pkg::WB_ALU;
		mem_read_o  = 1'b0;
		mem_write_o = 1'b0;
		jump_o      = 1'b0;

		case (opcode)
			rv_pkg::OPC_LUI:
			begin
				rf_we = 1'b1;
				imm_o = imm_u_type;
			end
			rv_pkg::OPC_OP_IMM:
			begin
				op_a_sel_o = rv_pkg::OPA_RS1;
				rf_we      = 1'b1;
				case (funct3)
					3'b000:  alu_op_o = rv_pkg::ALU_ADD;
					3'b010:  alu_op_o = rv_pkg::ALU_SLT;
					3'b100:  alu_op_o = rv_pkg::ALU_XOR;
					3'b110:  alu_op_o = rv_pkg::ALU_OR;
					3'b111:  alu_op_o = rv_pkg::ALU_AND;
					default: rf_we = 1'b0;
				endcase
			end
			rv_pkg::OPC_OP:
			begin
				op_a_sel_o = rv_pkg::OPA_RS1;
				op_b_sel_o = rv_pkg::OPB_RS2;
				rf_we      = 1'b1;
				case ({funct7_5, funct3})
					4'b0_000: alu_op_o = rv_pkg::ALU_ADD;
					4'b1_000: alu_op_o = rv_pkg::ALU_SUB;
					4'b0_111: alu_op_o = rv_pkg::ALU_AND;
					4'b0_110: alu_op_o = rv_pkg::ALU_OR;
					4'b0_100: alu_op_o = rv_pkg::ALU_XOR;
					4'b0_010: alu_op_o = rv_pkg::ALU_SLT;
					4'b0_001: alu_op_o = rv_pkg::ALU_SLL;
					4'b0_101: alu_op_o = rv_pkg::ALU_SRL;
					default:  rf_we = 1'b0;
				endcase
			end
			rv_pkg::OPC_LOAD:
				// Word accesses only
				if (funct3 == 3'b010)
				begin
					op_a_sel_o = rv_pkg::OPA_RS1;
					alu_op_o   = rv_pkg::ALU_ADD;
					rf_we      = 1'b1;
					mem_read_o = 1'b1;
					wb_sel_o   = rv_pkg::WB_MEM;
				end
			rv_pkg::OPC_STORE:
				if (funct3 == 3'b010)
				begin
					op_a_sel_o  = rv_pkg::OPA_RS1;
					alu_op_o    = rv_pkg::ALU_ADD;
					imm_o       = imm_s_type;
					mem_write_o = 1'b1;
				end
			rv_pkg::OPC_BRANCH:
			begin
				imm_o = imm_b_type;
				case (funct3)
					3'b000:  br_cond_o = rv_pkg::BR_EQ;
					3'b001:  br_cond_o = rv_pkg::BR_NE;
					3'b100:  br_cond_o = rv_pkg::BR_LT;
					default: br_cond_o = rv_pkg::BR_NONE;
				endcase
			end
			rv_pkg::OPC_JAL:
			begin
				imm_o    = imm_j_type;
				jump_o   = 1'b1;
				rf_we    = 1'b1;
				wb_sel_o = rv_pkg::WB_PC4;
			end
			default:
				rf_we = 1'b0;
		endcase
	end

	// x0 is never written
	assign rf_we_o = rf_we && (rd_addr_o != '0);

endmodule

`default_nettype wire

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu
(
	input  var rv_pkg::alu_op_e      alu_op_i,
	input  var rv_pkg::op_a_sel_e    op_a_sel_i,
	input  var rv_pkg::op_b_sel_e    op_b_sel_i,
	input  var rv_pkg::br_cond_e     br_cond_i,
	input  wire  [rv_pkg::XLEN-1:0]  rs1_data_i,
	input  wire  [rv_pkg::XLEN-1:0]  rs2_data_i,
	input  wire  [rv_pkg::XLEN-1:0]  imm_i,
	output logic [rv_pkg::XLEN-1:0]  alu_result_o,
	output logic                     branch_taken_o
);

	logic [rv_pkg::XLEN-1:0]  operand_a;
	logic [rv_pkg::XLEN-1:0]  operand_b;
	logic                     less_than;

	assign operand_a = (op_a_sel_i == rv_pkg::OPA_ZERO) ? '0 : rs1_data_i;
	assign operand_b = (op_b_sel_i == rv_pkg::OPB_IMM) ? imm_i : rs2_data_i;
	assign less_than = $signed(operand_a) < $signed(operand_b);

	always_comb
	begin
		case (alu_op_i)
			rv_pkg::ALU_ADD:    alu_result_o = operand_a + operand_b;
			rv_pkg::ALU_SUB:    alu_result_o = operand_a - operand_b;
			rv_pkg::ALU_AND:    alu_result_o = operand_a & operand_b;
			rv_pkg::ALU_OR:     alu_result_o = operand_a | operand_b;
			rv_pkg::ALU_XOR:    alu_result_o = operand_a ^ operand_b;
			rv_pkg::ALU_SLT:    alu_result_o = {{(rv_pkg::XLEN-1){1'b0}}, less_than};
			rv_pkg::ALU_SLL:    alu_result_o = operand_a << operand_b[4:0];
			rv_pkg::ALU_SRL:    alu_result_o = operand_a >> operand_b[4:0];
			default:            alu_result_o = operand_b;
		endcase
	end

	// Compare always uses the register values
	always_comb
	begin
		case (br_cond_i)
			rv_pkg::BR_EQ: branch_taken_o = (rs1_data_i == rs2_data_i);
			rv_pkg::BR_NE: branch_taken_o = (rs1_data_i != rs2_data_i);
			rv_pkg::BR_LT: branch_taken_o = $signed(rs1_data_i) < $signed(rs2_data_i);
			default:       branch_taken_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file
(
	input  wire                            clk,
	input  wire                            arst_n_i,
	input  wire  [rv_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
	input  wire  [rv_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
	input  wire  [rv_pkg::REG_ADDR_W-1:0]  rd_addr_i,
	input  wire                            rd_we_i,
	input  wire  [rv_pkg::XLEN-1:0]        rd_data_i,
	output logic [rv_pkg::XLEN-1:0]        rs1_data_o,
	output logic [rv_pkg::XLEN-1:0]        rs2_data_o
);

	logic [rv_pkg::XLEN-1:0] regs_q [2**rv_pkg::REG_ADDR_W];

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++)
				regs_q[i] <= '0;
		end
		else if (rd_we_i && rd_addr_i != '0)
			regs_q[rd_addr_i] <= rd_data_i;
	end

	// x0 reads as zero
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

// ==== hw/rv_mem_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mem_writeback
(
	input  wire                      clk,
	input  wire                      arst_n_i,
	input  wire                      exec_i,
	input  wire                      mem_read_i,
	input  wire                      mem_write_i,
	input  wire                      rf_we_i,
	input  var rv_pkg::wb_sel_e      wb_sel_i,
	input  wire  [rv_pkg::XLEN-1:0]  alu_result_i,
	input  wire  [rv_pkg::XLEN-1:0]  rs2_data_i,
	input  wire  [rv_pkg::XLEN-1:0]  instr_addr_i,
	input  wire                      dmem_ready_i,
	input  wire  [rv_pkg::XLEN-1:0]  dmem_rdata_i,
	output logic                     dmem_valid_o,
	output logic                     dmem_write_o,
	output logic [rv_pkg::XLEN-1:0]  dmem_addr_o,
	output logic [rv_pkg::XLEN-1:0]  dmem_wdata_o,
	output logic                     rd_we_o,
	output logic [rv_pkg::XLEN-1:0]  rd_data_o,
	output logic                     retire_o
);

	logic mem_access;
	logic req_done_q;
	logic handshake;

	assign mem_access = mem_read_i || mem_write_i;
	assign handshake  = dmem_valid_o && dmem_ready_i;

	// One transfer per instruction
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			req_done_q <= 1'b0;
		else if (!exec_i)
			req_done_q <= 1'b0;
		else if (handshake)
			req_done_q <= 1'b1;
	end

	// Address and data stay put while EXEC holds the instruction
	assign dmem_valid_o = exec_i && mem_access && !req_done_q;
	assign dmem_write_o = exec_i && mem_write_i;
	assign dmem_addr_o  = alu_result_i;
	assign dmem_wdata_o = rs2_data_i;

	assign retire_o = exec_i && (mem_access ? handshake : 1'b1);
	assign rd_we_o  = rf_we_i && retire_o;

	always_comb
	begin
		case (wb_sel_i)
			rv_pkg::WB_MEM: rd_data_o = dmem_rdata_i;
			rv_pkg::WB_PC4: rd_data_o = instr_addr_i + rv_pkg::XLEN'(4);
			default:        rd_data_o = alu_result_i;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core
(
	input  wire                      clk,
	input  wire                      arst_n_i,

	// Instruction memory
	output logic                     imem_valid_o,
	input  wire                      imem_ready_i,
	output logic [rv_pkg::XLEN-1:0]  imem_addr_o,
	input  wire  [rv_pkg::XLEN-1:0]  imem_rdata_i,

	// Data memory
	output logic                     dmem_valid_o,
	input  wire                      dmem_ready_i,
	output logic                     dmem_write_o,
	output logic [rv_pkg::XLEN-1:0]  dmem_addr_o,
	output logic [rv_pkg::XLEN-1:0]  dmem_wdata_o,
	input  wire  [rv_pkg::XLEN-1:0]  dmem_rdata_i
);

	logic [rv_pkg::XLEN-1:0]        instr;
	logic [rv_pkg::XLEN-1:0]        instr_addr;
	logic                           exec;
	logic                           retire;

	logic [rv_pkg::REG_ADDR_W-1:0]  rs1_addr;
	logic [rv_pkg::REG_ADDR_W-1:0]  rs2_addr;
	logic [rv_pkg::REG_ADDR_W-1:0]  rd_addr;
	logic                           rf_we;
	logic [rv_pkg::XLEN-1:0]        rs1_data;
	logic [rv_pkg::XLEN-1:0]        rs2_data;
	logic                           rd_we;
	logic [rv_pkg::XLEN-1:0]        rd_data;

	rv_pkg::alu_op_e                alu_op;
	rv_pkg::op_a_sel_e              op_a_sel;
	rv_pkg::op_b_sel_e              op_b_sel;
	rv_pkg::br_cond_e               br_cond;
	rv_pkg::wb_sel_e                wb_sel;
	logic [rv_pkg::XLEN-1:0]        imm;
	logic                           mem_read;
	logic                           mem_write;
	logic                           jump;

	logic [rv_pkg::XLEN-1:0]        alu_result;
	logic                           branch_taken;

	rv_fetch fetch
	(
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.imem_ready_i   (imem_ready_i),
		.imem_rdata_i   (imem_rdata_i),
		.retire_i       (retire),
		.branch_taken_i (branch_taken),
		.jump_i         (jump),
		.imm_i          (imm),
		.imem_valid_o   (imem_valid_o),
		.imem_addr_o    (imem_addr_o),
		.instr_o        (instr),
		.instr_addr_o   (instr_addr),
		.exec_o         (exec)
	);

	rv_decoder decoder
	(
		.instr_i     (instr),
		.rs1_addr_o  (rs1_addr),
		.rs2_addr_o  (rs2_addr),
		.rd_addr_o   (rd_addr),
		.rf_we_o     (rf_we),
		.alu_op_o    (alu_op),
		.op_a_sel_o  (op_a_sel),
		.op_b_sel_o  (op_b_sel),
		.br_cond_o   (br_cond),
		.imm_o       (imm),
		.wb_sel_o    (wb_sel),
		.mem_read_o  (mem_read),
		.mem_write_o (mem_write),
		.jump_o      (jump)
	);

	rv_alu alu
	(
		.alu_op_i       (alu_op),
		.op_a_sel_i     (op_a_sel),
		.op_b_sel_i     (op_b_sel),
		.br_cond_i      (br_cond),
		.rs1_data_i     (rs1_data),
		.rs2_data_i     (rs2_data),
		.imm_i          (imm),
		.alu_result_o   (alu_result),
		.branch_taken_o (branch_taken)
	);

	rv_reg_file reg_file
	(
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rd_addr_i  (rd_addr),
		.rd_we_i    (rd_we),
		.rd_data_i  (rd_data),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	rv_mem_writeback mem_writeback
	(
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.exec_i       (exec),
		.mem_read_i   (mem_read),
		.mem_write_i  (mem_write),
		.rf_we_i      (rf_we),
		.wb_sel_i     (wb_sel),
		.alu_result_i (alu_result),
		.rs2_data_i   (rs2_data),
		.instr_addr_i (instr_addr),
		.dmem_ready_i (dmem_ready_i),
		.dmem_rdata_i (dmem_rdata_i),
		.dmem_valid_o (dmem_valid_o),
		.dmem_write_o (dmem_write_o),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.rd_we_o      (rd_we),
		.rd_data_o    (rd_data),
		.retire_o     (retire)
	);

endmodule

`default_nettype wire

// ==== bench/rv_core_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions
(
	input wire        clk,
	input wire        arst_n_i,
	input wire        imem_valid_i,
	input wire        imem_ready_i,
	input wire [31:0] imem_addr_i,
	input wire        dmem_valid_i,
	input wire        dmem_ready_i,
	input wire        dmem_write_i,
	input wire [31:0] dmem_addr_i
);

	int fail_count = 0;

	// Request held until accepted
	imem_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		imem_valid_i && !imem_ready_i |=> imem_valid_i && $stable(imem_addr_i))
		else
		begin
			$error("imem request dropped or changed before ready");
			fail_count++;
		end

	dmem_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		dmem_valid_i && !dmem_ready_i |=> dmem_valid_i && $stable(dmem_addr_i)
		&& $stable(dmem_write_i))
		else
		begin
			$error("dmem request dropped or changed before ready");
			fail_count++;
		end

	reset_idle: assert property (@(posedge clk)
		!arst_n_i |-> !imem_valid_i && !dmem_valid_i)
		else
		begin
			$error("valid high during reset");
			fail_count++;
		end

	one_port: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(imem_valid_i && dmem_valid_i))
		else
		begin
			$error("both memory ports requested at once");
			fail_count++;
		end

endmodule

bind rv_core rv_core_assertions assertions0
(
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.imem_valid_i (imem_valid_o),
	.imem_ready_i (imem_ready_i),
	.imem_addr_i  (imem_addr_o),
	.dmem_valid_i (dmem_valid_o),
	.dmem_ready_i (dmem_ready_i),
	.dmem_write_i (dmem_write_o),
	.dmem_addr_i  (dmem_addr_o)
);

`default_nettype wire

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_WAIT = 4;
	// Worst case cycles per instruction
	localparam int MAX_INSTR_CYCLES = 2 * MAX_WAIT + 4;
	localparam int VEC_DEPTH = 256;
	localparam int PROG_BASE = 'h10;
	localparam int STORE_BASE = 'h40;
	localparam int FETCH_BASE = 'h80;
	localparam logic [31:0] NOP_WORD = 32'h0000_0013;

	logic        clk;
	logic        arst_n_i;
	logic        imem_valid_o;
	logic        imem_ready_i;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_rdata_i;
	logic        dmem_valid_o;
	logic        dmem_ready_i;
	logic        dmem_write_o;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_wdata_o;
	logic [31:0] dmem_rdata_i;

	logic [31:0] vec [0:VEC_DEPTH-1];
	logic [31:0] dmem_words [0:1023];

	int seed;
	int prog_count;
	int store_total;
	int fetch_total;
	int fetch_count;
	int store_count;
	int fetch_errors;
	int store_errors;
	int assert_errors;
	int other_errors;
	int imem_wait;
	int dmem_wait;
	bit loaded;

	rv_core dut0
	(
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.imem_valid_o (imem_valid_o),
		.imem_ready_i (imem_ready_i),
		.imem_addr_o  (imem_addr_o),
		.imem_rdata_i (imem_rdata_i),
		.dmem_valid_o (dmem_valid_o),
		.dmem_ready_i (dmem_ready_i),
		.dmem_write_o (dmem_write_o),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_rdata_i (dmem_rdata_i)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function int draw_wait_cycles();
		int r;
		r = $random(seed);
		if (r < 0)
			r = -r;
		return r % (MAX_WAIT + 1);
	endfunction

	function logic [31:0] program_word(input logic [31:0] addr);
		int idx;
		idx = int'(addr[31:2]);
		if (idx < prog_count)
			return vec[PROG_BASE + idx];
		return NOP_WORD;
	endfunction

	// Instruction memory with random wait states
	always
	begin
		@(posedge clk);
		#1;
		if (imem_ready_i)
		begin
			imem_ready_i = 1'b0;
			imem_wait = draw_wait_cycles();
		end
		else if (imem_valid_o)
		begin
			if (imem_wait == 0)
			begin
				imem_rdata_i = program_word(imem_addr_o);
				imem_ready_i = 1'b1;
			end
			else
				imem_wait = imem_wait - 1;
		end
	end

	// Data memory with load data valid alongside ready
	always
	begin
		@(posedge clk);
		#1;
		if (dmem_ready_i)
		begin
			dmem_ready_i = 1'b0;
			dmem_wait = draw_wait_cycles();
		end
		else if (dmem_valid_o)
		begin
			if (dmem_wait == 0)
			begin
				dmem_rdata_i = dmem_words[dmem_addr_o[11:2]];
				dmem_ready_i = 1'b1;
			end
			else
				dmem_wait = dmem_wait - 1;
		end
	end

	// Handshakes sampled mid cycle before their completing edge
	always @(negedge clk)
	begin
		if (arst_n_i && imem_valid_o && imem_ready_i)
		begin
			if (imem_addr_o !== vec[FETCH_BASE + fetch_count])
			begin
				$display("[FAIL] fetch %0d expected %h actual %h", fetch_count,
					vec[FETCH_BASE + fetch_count], imem_addr_o);
				fetch_errors++;
			end
			fetch_count++;
		end
		if (arst_n_i && dmem_valid_o && dmem_ready_i && dmem_write_o)
		begin
			if (store_count >= store_total)
			begin
				$display("Unexpected store of %h to %h", dmem_wdata_o, dmem_addr_o);
				other_errors++;
			end
			else
			begin
				if (dmem_addr_o !== vec[STORE_BASE + 2 * store_count])
				begin
					$display("[FAIL] store %0d address expected %h actual %h", store_count,
						vec[STORE_BASE + 2 * store_count], dmem_addr_o);
					store_errors++;
				end
				if (dmem_wdata_o !== vec[STORE_BASE + 2 * store_count + 1])
				begin
					$display("[FAIL] store %0d data expected %h actual %h", store_count,
						vec[STORE_BASE + 2 * store_count + 1], dmem_wdata_o);
					store_errors++;
				end
			end
			dmem_words[dmem_addr_o[11:2]] = dmem_wdata_o;
			store_count++;
		end
	end

	initial
	begin
		int timeout_ns;
		wait (loaded);
		timeout_ns = (2 * fetch_total * MAX_INSTR_CYCLES + RESET_CYCLES) * CLK_PERIOD;
		#(timeout_ns);
		$display("Timeout after %0d ns with %0d of %0d fetches done", timeout_ns,
			fetch_count, fetch_total);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		int total;
		seed = 8;
		clk = 1'b0;
		arst_n_i = 1'b0;
		imem_ready_i = 1'b0;
		imem_rdata_i = '0;
		dmem_ready_i = 1'b0;
		dmem_rdata_i = '0;
		fetch_count = 0;
		store_count = 0;
		fetch_errors = 0;
		store_errors = 0;
		assert_errors = 0;
		other_errors = 0;
		$readmemh("bench/rv_core_vectors.txt", vec);
		prog_count = int'(vec[0]);
		store_total = int'(vec[1]);
		fetch_total = int'(vec[2]);
		// Fill value tied to the full byte address
		for (int i = 0; i < 1024; i++)
			dmem_words[i] = 32'hCAFE_0000 ^ (i << 2);
		imem_wait = draw_wait_cycles();
		dmem_wait = draw_wait_cycles();
		loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n_i = 1'b1;

		wait (fetch_count == fetch_total);
		@(posedge clk);
		if (store_count != store_total)
		begin
			$display("Only %0d of %0d stores were seen", store_count, store_total);
			other_errors++;
		end
		assert_errors = dut0.assertions0.fail_count;

		total = fetch_errors + store_errors + assert_errors + other_errors;
		$display("Errors: %0d total, %0d fetch, %0d store, %0d assertion, %0d other", total,
			fetch_errors, store_errors, assert_errors, other_errors);
		if (total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/rv_core_vectors.txt ====
// Header: program word count, store count, fetch count
// @10 program words, @40 store address/data pairs, @80 fetch addresses
@000
0000002C 00000010 00000028
@010
123450B7 06400113 FF900193 00310233 403102B3 00317333 003163B3 00314433
0021A4B3 00209533 0021D5B3 0F01F613 F0016693 7FF0C713 FFF12793 03710013
10002803 20102023 20402223 20502423 20602623 20702823 20802A23 20902C23
20A02E23 22B02023 22C02223 22D02423 22E02623 22F02823 22002A23 23002C23
00310463 00311463 30202023 0021C463 30202023 00314463 12345F8B 00C008EF
30202023 30202023 23102E23 0000006F
@040
00000200 12345000 00000204 0000005D 00000208 0000006B 0000020C 00000060
00000210 FFFFFFFD 00000214 FFFFFF9D 00000218 00000001 0000021C 23450000
00000220 0FFFFFFF 00000224 000000F0 00000228 FFFFFF64 0000022C 123457FF
00000230 00000000 00000234 00000000 00000238 CAFE0100 0000023C 000000A0
@080
00000000 00000004 00000008 0000000C 00000010 00000014 00000018 0000001C
00000020 00000024 00000028 0000002C 00000030 00000034 00000038 0000003C
00000040 00000044 00000048 0000004C 00000050 00000054 00000058 0000005C
00000060 00000064 00000068 0000006C 00000070 00000074 00000078 0000007C
00000080 00000084 0000008C 00000094 00000098 0000009C 000000A8 000000AC

// ==== rv_core.f ====
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_reg_file.sv
hw/rv_mem_writeback.sv
hw/rv_core.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module rv_core_tb \
	-f rv_core.f \
	-o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"
